//--- game_pkg.sv
package game_pkg;

    // ==================================================
    // tile and scene encodings
    // ==================================================
    typedef enum logic [3:0] {
        tile_empty   = 4'h0,  // must stay zero
        tile_spike   = 4'h1,
        tile_gate_1  = 4'h2,
        tile_gate_2  = 4'h3,
        tile_gate_3  = 4'h4,
        tile_plate_1 = 4'h5,
        tile_plate_2 = 4'h6,
        tile_plate_3 = 4'h7,
        tile_exit    = 4'h8,
        tile_wall    = 4'h9
    } tile_t;

    typedef enum logic [1:0] {
        scene_start = 2'd0,
        scene_play  = 2'd1,
        scene_lose  = 2'd2
    } scene_t;

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } player_cmd_t;

    // top-left corner of the 32x32 sprite, in pixels
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } player_pos_t;

    typedef logic [2:0] gate_mask_t;  // bit k-1 set = gate k open

    // ==================================================
    // geometry
    // ==================================================
    localparam logic [9:0] TILE_SIZE   = 10'd32;
    localparam logic [9:0] MAP_COLS    = 10'd20;
    localparam logic [9:0] MAP_ROWS    = 10'd15;
    localparam logic [9:0] SCREEN_W    = 10'd640;
    localparam logic [9:0] FLOOR_Y     = 10'd416;
    localparam logic [9:0] STEP        = 10'd5;
    localparam logic [9:0] JUMP_HEIGHT = 10'd64;
    localparam logic [9:0] CEILING_Y   = 10'd10;
    localparam logic [9:0] FOOT_INSET  = 10'd4;

    localparam player_pos_t P1_START = '{x: 10'd32, y: 10'd320};
    localparam player_pos_t P2_START = '{x: 10'd32, y: 10'd416};

    // fixed level, column 0 sits in the top nibble of each row
    function automatic tile_t tile_at(input logic [4:0] row, input logic [4:0] col);
        logic [79:0] r;
        case (row)
            5'd1:    r = {{10{tile_empty}}, {10{tile_wall}}};
            5'd3, 5'd5, 5'd7:
                     r = {{10{tile_wall}}, {10{tile_empty}}};
            5'd9:    r = {{7{tile_empty}}, tile_gate_1, {4{tile_empty}}, tile_gate_2,
                          {4{tile_empty}}, tile_gate_3, tile_empty, tile_exit};
            5'd10:   r = {{5{tile_empty}}, tile_spike, tile_empty, tile_gate_1,
                          {4{tile_empty}}, tile_gate_2, {4{tile_empty}}, tile_gate_3,
                          tile_empty, tile_exit};
            5'd11:   r = {{2{tile_wall}}, {3{tile_plate_1}}, {15{tile_wall}}};
            5'd13:   r = {{3{tile_empty}}, tile_spike, tile_empty, tile_gate_1,
                          {9{tile_empty}}, {5{tile_plate_3}}};
            5'd14:   r = {{5{tile_wall}}, {5{tile_plate_1}}, {5{tile_plate_2}}, {5{tile_wall}}};
            default: r = '0;  // open rows
        endcase
        if (row >= MAP_ROWS) return tile_wall;    // below the map counts as floor
        if (col >= MAP_COLS) return tile_empty;
        return tile_t'(r[(MAP_COLS - 10'd1 - col) * 4 +: 4]);
    endfunction

    function automatic logic is_solid(input tile_t t, input gate_mask_t gates);
        case (t)
            tile_gate_1: return !gates[0];
            tile_gate_2: return !gates[1];
            tile_gate_3: return !gates[2];
            tile_plate_1, tile_plate_2, tile_plate_3, tile_exit, tile_wall:
                return 1'b1;
            default: return 1'b0;  // empty and spike
        endcase
    endfunction

endpackage

//--- game_timer.sv
`timescale 1ns/1ps

module game_timer #(
    parameter int TICK_DIV     = 5_000_000,
    parameter int SPIKE_PERIOD = 8,
    parameter int SPIKE_ARMED  = 1
) (
    input  logic clk_25MHz,
    input  logic rst,
    output logic tick,
    output logic spike_on
);

    localparam int DIV_W   = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int PHASE_W = (SPIKE_PERIOD > 1) ? $clog2(SPIKE_PERIOD) : 1;

    logic [DIV_W-1:0]   div_cnt;
    logic [PHASE_W-1:0] phase;      // ticks seen, mod SPIKE_PERIOD
    logic [PHASE_W-1:0] phase_nxt;

    assign tick      = (div_cnt == DIV_W'(TICK_DIV - 1));
    assign phase_nxt = (phase == PHASE_W'(SPIKE_PERIOD - 1)) ? '0 : phase + 1'b1;

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            div_cnt  <= '0;
            phase    <= '0;
            spike_on <= 1'b0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                phase    <= phase_nxt;
                spike_on <= (phase_nxt >= PHASE_W'(SPIKE_PERIOD - SPIKE_ARMED)); // tail of cycle
            end
        end
    end

    // every consumer expects a single-cycle strobe
    a_tick_single: assert property (@(posedge clk_25MHz) disable iff (rst) tick |=> !tick)
        else $error("game_timer: tick high on two consecutive cycles");

endmodule

//--- button_debounce.sv
`timescale 1ns/1ps

module button_debounce #(
    parameter int DEBOUNCE_LEN = 250_000
) (
    input  logic clk_25MHz,
    input  logic rst,
    input  logic raw,
    output logic pulse
);

    localparam int CNT_W = $clog2(DEBOUNCE_LEN + 1);

    // consecutive high samples, saturates so a held button fires once
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            stable_cnt <= '0;
            pulse      <= 1'b0;
        end else begin
            // fire on the sample that completes the stable run
            pulse <= raw && (stable_cnt == CNT_W'(DEBOUNCE_LEN - 1));
            if (!raw) begin
                stable_cnt <= '0;    // any low sample restarts the run
            end else if (stable_cnt != CNT_W'(DEBOUNCE_LEN)) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

//--- player_physics.sv
`timescale 1ns/1ps

module player_physics #(
    parameter game_pkg::player_pos_t START_POS = '{x: 10'd32, y: 10'd320}
) (
    input  logic                  clk_25MHz,
    input  logic                  rst,
    input  logic                  tick,
    input  game_pkg::scene_t      scene,
    input  game_pkg::player_cmd_t cmd,
    input  game_pkg::gate_mask_t  gate_open,
    output game_pkg::player_pos_t pos
);

    import game_pkg::*;

    logic       jumping;
    logic [9:0] jump_start_y;  // y at take-off
    logic [9:0] rise;

    // ==================================================
    // collision probes
    // ==================================================
    logic [9:0] left_x, right_x;   // leading edge after a step
    logic [9:0] top_y, mid_y;      // side probe heights
    logic [9:0] foot_l, foot_r;    // inset foot columns
    logic [9:0] below_y, land_y, above_y;
    logic       wall_l, wall_r, grounded, landing, ceiling;

    assign left_x  = pos.x - STEP;
    assign right_x = pos.x + TILE_SIZE - 10'd1 + STEP;
    assign top_y   = pos.y + FOOT_INSET;
    assign mid_y   = pos.y + (TILE_SIZE >> 1);
    assign foot_l  = pos.x + FOOT_INSET;
    assign foot_r  = pos.x + TILE_SIZE - 10'd1 - FOOT_INSET;
    assign below_y = pos.y + TILE_SIZE;               // first pixel under the feet
    assign land_y  = pos.y + TILE_SIZE - 10'd1 + STEP; // bottom pixel after one fall step
    assign above_y = pos.y - STEP;
    assign rise    = jump_start_y - pos.y;

    assign wall_l = (pos.x < STEP)
                  || is_solid(tile_at(top_y[9:5], left_x[9:5]), gate_open)
                  || is_solid(tile_at(mid_y[9:5], left_x[9:5]), gate_open);

    assign wall_r = (pos.x > SCREEN_W - TILE_SIZE - STEP)
                  || is_solid(tile_at(top_y[9:5], right_x[9:5]), gate_open)
                  || is_solid(tile_at(mid_y[9:5], right_x[9:5]), gate_open);

    assign grounded = (pos.y >= FLOOR_Y)
                    || is_solid(tile_at(below_y[9:5], foot_l[9:5]), gate_open)
                    || is_solid(tile_at(below_y[9:5], foot_r[9:5]), gate_open);

    assign landing = is_solid(tile_at(land_y[9:5], foot_l[9:5]), gate_open)
                   || is_solid(tile_at(land_y[9:5], foot_r[9:5]), gate_open);

    assign ceiling = (pos.y < STEP)
                   || is_solid(tile_at(above_y[9:5], foot_l[9:5]), gate_open)
                   || is_solid(tile_at(above_y[9:5], foot_r[9:5]), gate_open);

    // ==================================================
    // per-tick motion
    // ==================================================
    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            pos          <= START_POS;
            jumping      <= 1'b0;
            jump_start_y <= '0;
        end else if (tick) begin
            if (scene == scene_start) begin
                pos     <= START_POS;  // level reload
                jumping <= 1'b0;
            end else if (scene == scene_play) begin
                if (cmd.left) begin
                    if (!wall_l) pos.x <= pos.x - STEP;
                end else if (cmd.right && !wall_r) begin
                    pos.x <= pos.x + STEP;
                end

                if (jumping) begin
                    if (ceiling || rise >= JUMP_HEIGHT || pos.y <= CEILING_Y)
                        jumping <= 1'b0;  // apex, fall from next tick
                    else
                        pos.y <= pos.y - STEP;
                end else if (grounded) begin
                    jumping <= cmd.jump;
                    if (cmd.jump)
                        jump_start_y <= pos.y;
                    pos.y   <= (pos.y >= FLOOR_Y) ? FLOOR_Y
                                                  : {below_y[9:5], 5'd0} - TILE_SIZE;
                end else if (landing) begin
                    pos.y <= {land_y[9:5], 5'd0} - TILE_SIZE;  // snap onto tile top
                end else if (pos.y + STEP >= FLOOR_Y) begin
                    pos.y <= FLOOR_Y;
                end else begin
                    pos.y <= pos.y + STEP;
                end
            end
        end
    end

    a_x_on_screen: assert property (@(posedge clk_25MHz) disable iff (rst)
        pos.x <= SCREEN_W - TILE_SIZE)
        else $error("player_physics: x beyond right screen edge");

    a_y_above_floor: assert property (@(posedge clk_25MHz) disable iff (rst)
        pos.y <= FLOOR_Y)
        else $error("player_physics: y below floor");

endmodule

//--- level_state.sv
`timescale 1ns/1ps

module level_state (
    input  logic                  clk_25MHz,
    input  logic                  rst,
    input  game_pkg::scene_t      scene,
    input  logic                  spike_on,
    input  game_pkg::player_pos_t pos_p1,
    input  game_pkg::player_pos_t pos_p2,
    output game_pkg::gate_mask_t  gate_open,
    output logic                  spike_hit
);

    import game_pkg::*;

    player_pos_t pl [2];
    logic [1:0]  on_spike;  // per player, spike under a foot

    assign pl[0] = pos_p1;
    assign pl[1] = pos_p2;

    always_comb begin
        logic [9:0] foot_l;
        logic [9:0] foot_r;
        logic [9:0] below_y;
        logic [9:0] bottom_y;
        gate_open = '0;
        on_spike  = '0;
        for (int i = 0; i < 2; i++) begin
            foot_l   = pl[i].x + FOOT_INSET;
            foot_r   = pl[i].x + TILE_SIZE - 10'd1 - FOOT_INSET;
            below_y  = pl[i].y + TILE_SIZE;
            bottom_y = pl[i].y + TILE_SIZE - 10'd1;
            // plates judged by the left foot only
            case (tile_at(below_y[9:5], foot_l[9:5]))
                tile_plate_1: gate_open[0] = 1'b1;
                tile_plate_2: gate_open[1] = 1'b1;
                tile_plate_3: gate_open[2] = 1'b1;
                default: ;
            endcase
            if (tile_at(bottom_y[9:5], foot_l[9:5]) == tile_spike
                    || tile_at(bottom_y[9:5], foot_r[9:5]) == tile_spike)
                on_spike[i] = 1'b1;
        end
    end

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst)
            spike_hit <= 1'b0;
        else
            spike_hit <= (scene == scene_play) && spike_on && (|on_spike);
    end

endmodule

//--- scene_fsm.sv
`timescale 1ns/1ps

module scene_fsm #(
    parameter int LOSE_TICKS = 25
) (
    input  logic             clk_25MHz,
    input  logic             rst,
    input  logic             tick,
    input  logic             start_pulse,
    input  logic             spike_hit,
    output game_pkg::scene_t scene
);

    import game_pkg::*;

    localparam int LOSE_W = $clog2(LOSE_TICKS + 1);

    logic [LOSE_W-1:0] lose_cnt;  // ticks spent in scene_lose

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            scene    <= scene_start;
            lose_cnt <= '0;
        end else begin
            case (scene)
                scene_start: if (start_pulse) scene <= scene_play;
                scene_play:  if (spike_hit) scene <= scene_lose;
                scene_lose: begin
                    if (tick) begin
                        if (lose_cnt == LOSE_W'(LOSE_TICKS - 1)) begin
                            scene    <= scene_start;
                            lose_cnt <= '0;
                        end else begin
                            lose_cnt <= lose_cnt + 1'b1;
                        end
                    end
                end
                default: scene <= scene_start;
            endcase
        end
    end

    a_scene_legal: assert property (@(posedge clk_25MHz) disable iff (rst)
        scene inside {scene_start, scene_play, scene_lose})
        else $error("scene_fsm: illegal scene encoding");

endmodule

//--- game_top.sv
`timescale 1ns/1ps

module game_top #(
    parameter int TICK_DIV     = 5_000_000,  // 5 Hz game tick
    parameter int SPIKE_PERIOD = 8,
    parameter int SPIKE_ARMED  = 1,
    parameter int DEBOUNCE_LEN = 250_000,    // 10 ms
    parameter int LOSE_TICKS   = 25
) (
    input  logic                  clk_25MHz,
    input  logic                  rst,
    input  logic                  start_btn,
    input  game_pkg::player_cmd_t cmd_p1,
    input  game_pkg::player_cmd_t cmd_p2,
    output game_pkg::scene_t      scene,
    output game_pkg::player_pos_t pos_p1,
    output game_pkg::player_pos_t pos_p2,
    output game_pkg::gate_mask_t  gate_open,
    output logic                  spike_on
);

    import game_pkg::*;

    logic tick;
    logic start_pulse;
    logic spike_hit;

    // ==================================================
    // timing and input
    // ==================================================
    game_timer #(
        .TICK_DIV    (TICK_DIV),
        .SPIKE_PERIOD(SPIKE_PERIOD),
        .SPIKE_ARMED (SPIKE_ARMED)
    ) timer_i (
        .clk_25MHz(clk_25MHz),
        .rst      (rst),
        .tick     (tick),
        .spike_on (spike_on)
    );

    button_debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) start_db_i (
        .clk_25MHz(clk_25MHz),
        .rst      (rst),
        .raw      (start_btn),
        .pulse    (start_pulse)
    );

    // ==================================================
    // players and level
    // ==================================================
    player_physics #(.START_POS(P1_START)) p1_physics (
        .clk_25MHz(clk_25MHz),
        .rst      (rst),
        .tick     (tick),
        .scene    (scene),
        .cmd      (cmd_p1),
        .gate_open(gate_open),
        .pos      (pos_p1)
    );

    player_physics #(.START_POS(P2_START)) p2_physics (
        .clk_25MHz(clk_25MHz),
        .rst      (rst),
        .tick     (tick),
        .scene    (scene),
        .cmd      (cmd_p2),
        .gate_open(gate_open),
        .pos      (pos_p2)
    );

    level_state level_i (
        .clk_25MHz(clk_25MHz),
        .rst      (rst),
        .scene    (scene),
        .spike_on (spike_on),
        .pos_p1   (pos_p1),
        .pos_p2   (pos_p2),
        .gate_open(gate_open),
        .spike_hit(spike_hit)
    );

    scene_fsm #(.LOSE_TICKS(LOSE_TICKS)) scene_i (
        .clk_25MHz  (clk_25MHz),
        .rst        (rst),
        .tick       (tick),
        .start_pulse(start_pulse),
        .spike_hit  (spike_hit),
        .scene      (scene)
    );

endmodule

//--- tb_game_top.sv
`timescale 1ns/1ps

module tb_game_top;

    import game_pkg::*;

    localparam int TICK_DIV     = 4;
    localparam int DEBOUNCE_LEN = 3;
    localparam int LOSE_TICKS   = 5;
    localparam int SPIKE_PERIOD = 8;
    localparam int SPIKE_ARMED  = 1;

    // test lengths in cycles, the watchdog is built from these
    localparam int T_START = 200;
    localparam int T_SPIKE = 3 * SPIKE_PERIOD * TICK_DIV;
    localparam int T_MOVE  = 600;
    localparam int T_GATE  = 300;
    localparam int T_LOSE  = 400;
    localparam int WATCHDOG_CYC = 20 + T_START + T_SPIKE + T_MOVE + T_GATE + 3 * T_LOSE + 500;

    logic        clk_25MHz;
    logic        rst;
    logic        start_btn;
    player_cmd_t cmd_p1, cmd_p2;
    scene_t      scene;
    player_pos_t pos_p1, pos_p2;
    gate_mask_t  gate_open;
    logic        spike_on;

    game_top #(
        .TICK_DIV    (TICK_DIV),
        .SPIKE_PERIOD(SPIKE_PERIOD),
        .SPIKE_ARMED (SPIKE_ARMED),
        .DEBOUNCE_LEN(DEBOUNCE_LEN),
        .LOSE_TICKS  (LOSE_TICKS)
    ) game_top_i (
        .clk_25MHz(clk_25MHz),
        .rst      (rst),
        .start_btn(start_btn),
        .cmd_p1   (cmd_p1),
        .cmd_p2   (cmd_p2),
        .scene    (scene),
        .pos_p1   (pos_p1),
        .pos_p2   (pos_p2),
        .gate_open(gate_open),
        .spike_on (spike_on)
    );

    logic [31:0] lfsr = 32'h0e13e238;
    int          err_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    string       cur_test = "reset";
    logic        monitor_on = 1'b0;
    int          cyc = 0;

    // ==================================================
    // reference model state
    // ==================================================
    int          m_div, m_phase, m_db_cnt, m_lose_cnt;
    logic        m_spike, m_pulse, m_hit, m_tick_edge;
    scene_t      m_scene;
    player_pos_t obs_p1, obs_p2;
    logic        obs_spike;
    scene_t      obs_scene;

    initial begin
        clk_25MHz = 1'b0;
        forever #20 clk_25MHz = ~clk_25MHz;
    end

    initial begin
        #(WATCHDOG_CYC * 40);
        $display("watchdog: the run took longer than the tests allow");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s: %s expected %0h actual %0h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic fail_words(input string msg);
        $display("%s: %s", cur_test, msg);
        err_count++;
    endtask

    // plate rule, left foot over the tile below the sprite
    function automatic logic [2:0] gates_from(input player_pos_t a, input player_pos_t b);
        logic [2:0] g;
        logic [9:0] fx;
        logic [9:0] by;
        g = '0;
        for (int i = 0; i < 2; i++) begin
            fx = (i == 0 ? a.x : b.x) + 10'd4;
            by = (i == 0 ? a.y : b.y) + 10'd32;
            case (tile_at(by[9:5], fx[9:5]))
                tile_plate_1: g[0] = 1'b1;
                tile_plate_2: g[1] = 1'b1;
                tile_plate_3: g[2] = 1'b1;
                default: ;
            endcase
        end
        return g;
    endfunction

    function automatic logic spike_under(input player_pos_t p);
        logic [9:0] fl, fr, bot;
        fl  = p.x + 10'd4;
        fr  = p.x + 10'd27;
        bot = p.y + 10'd31;
        return tile_at(bot[9:5], fl[9:5]) == tile_spike
            || tile_at(bot[9:5], fr[9:5]) == tile_spike;
    endfunction

    // top and middle probes at the foot columns, gates counted as open
    function automatic logic probes_clear(input player_pos_t p);
        logic [9:0] fl, fr, ty, my;
        fl = p.x + 10'd4;
        fr = p.x + 10'd27;
        ty = p.y + 10'd4;
        my = p.y + 10'd16;
        return !(is_solid(tile_at(ty[9:5], fl[9:5]), 3'b111)
              || is_solid(tile_at(ty[9:5], fr[9:5]), 3'b111)
              || is_solid(tile_at(my[9:5], fl[9:5]), 3'b111)
              || is_solid(tile_at(my[9:5], fr[9:5]), 3'b111));
    endfunction

    // ==================================================
    // model step on the rising edge, inputs are stable here
    // ==================================================
    always @(posedge clk_25MHz) begin
        logic   tk, pulse_n, hit_n;
        int     ph_n;
        scene_t sc_n;
        if (rst) begin
            m_div = 0;
            m_phase = 0;
            m_db_cnt = 0;
            m_lose_cnt = 0;
            m_spike = 0;
            m_pulse = 0;
            m_hit = 0;
            m_tick_edge = 0;
            m_scene = scene_start;
        end else begin
            cyc++;
            tk      = (m_div == TICK_DIV - 1);
            pulse_n = start_btn && (m_db_cnt == DEBOUNCE_LEN - 1);
            hit_n   = (m_scene == scene_play) && obs_spike
                   && (spike_under(obs_p1) || spike_under(obs_p2));
            sc_n    = m_scene;
            case (m_scene)
                scene_start: if (m_pulse) sc_n = scene_play;
                scene_play:  if (m_hit) sc_n = scene_lose;
                default: begin
                    if (tk) begin
                        if (m_lose_cnt == LOSE_TICKS - 1) begin
                            sc_n = scene_start;
                            m_lose_cnt = 0;
                        end else begin
                            m_lose_cnt++;
                        end
                    end
                end
            endcase
            if (tk) begin
                ph_n = (m_phase + 1) % SPIKE_PERIOD;
                m_phase = ph_n;
                m_spike = (ph_n >= SPIKE_PERIOD - SPIKE_ARMED);
            end
            m_div = tk ? 0 : m_div + 1;
            if (!start_btn) m_db_cnt = 0;
            else if (m_db_cnt != DEBOUNCE_LEN) m_db_cnt++;
            m_pulse = pulse_n;
            m_hit = hit_n;
            m_scene = sc_n;
            m_tick_edge = tk;
        end
    end

    // per-cycle checks on the falling edge, outputs are settled
    always @(negedge clk_25MHz) begin
        int dx;
        if (monitor_on) begin
            check("scene", m_scene, scene);
            check("spike_on", m_spike, spike_on);
            check("gate_open", gates_from(pos_p1, pos_p2), gate_open);
            if (!m_tick_edge && (pos_p1 !== obs_p1 || pos_p2 !== obs_p2))
                fail_words("a position changed without a tick");
            if (obs_scene == scene_play) begin
                dx = int'(pos_p1.x) - int'(obs_p1.x);
                if (dx != 0 && dx != 5 && dx != -5) fail_words("player 1 x step is not 0 or 5");
                dx = int'(pos_p2.x) - int'(obs_p2.x);
                if (dx != 0 && dx != 5 && dx != -5) fail_words("player 2 x step is not 0 or 5");
            end
            if (pos_p1.x > 608 || pos_p2.x > 608) fail_words("a player left the screen");
            if (pos_p1.y > 416 || pos_p2.y > 416) fail_words("a player is below the floor");
            if (!probes_clear(pos_p1) || !probes_clear(pos_p2))
                fail_words("a player probe rests inside a solid tile");
        end
        obs_p1    = pos_p1;
        obs_p2    = pos_p2;
        obs_spike = spike_on;
        obs_scene = scene;
    end

    task automatic random_cmds(input logic p1_on, input logic p2_on);
        logic [31:0] v;
        @(negedge clk_25MHz);
        take_bits(3, v);
        cmd_p1 = p1_on ? player_cmd_t'(v[2:0]) : '0;
        take_bits(3, v);
        cmd_p2 = p2_on ? player_cmd_t'(v[2:0]) : '0;
    endtask

    task automatic finish_test(input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", cur_test);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d errors", cur_test, err_count - errs_before);
            fail_count++;
        end
    endtask

    // holds the button until the scene enters play, returns cycles from press
    task automatic press_start(output int lat);
        int t0;
        @(negedge clk_25MHz);
        start_btn = 1'b1;
        t0 = cyc;
        while (scene != scene_play && cyc - t0 < 50) @(negedge clk_25MHz);
        lat = cyc - t0;
        if (scene != scene_play) fail_words("scene never reached play");
        start_btn = 1'b0;
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        int          e, lat, t0, ticks;
        logic [31:0] v;
        rst = 1'b1;
        start_btn = 1'b0;
        cmd_p1 = '0;
        cmd_p2 = '0;
        repeat (4) @(negedge clk_25MHz);
        rst = 1'b0;

        e = err_count;
        check("scene", scene_start, scene);
        check("pos_p1", P1_START, pos_p1);
        check("pos_p2", P2_START, pos_p2);
        check("gate_open", 0, gate_open);
        check("spike_on", 0, spike_on);
        monitor_on = 1'b1;
        finish_test(e);

        cur_test = "start_button";
        e = err_count;
        for (int i = 0; i < 20; i++) begin
            take_bits(1, v);
            start_btn = 1'b1;
            repeat (v[0] + 1) random_cmds(1'b1, 1'b1);  // 1 or 2 high cycles
            start_btn = 1'b0;
            random_cmds(1'b1, 1'b1);
        end
        check("scene after glitches", scene_start, scene);
        check("pos_p1 in start", P1_START, pos_p1);
        check("pos_p2 in start", P2_START, pos_p2);
        cmd_p1 = '0;
        cmd_p2 = '0;
        press_start(lat);
        check("press to play latency", DEBOUNCE_LEN + 1, lat);
        finish_test(e);

        cur_test = "spike_cycle";
        e = err_count;
        repeat (T_SPIKE) @(negedge clk_25MHz);
        finish_test(e);

        cur_test = "movement";
        e = err_count;
        repeat (T_MOVE) random_cmds(1'b1, 1'b1);
        finish_test(e);

        cur_test = "gates";
        e = err_count;
        repeat (T_GATE) random_cmds(1'b1, 1'b0);
        cmd_p1 = '0;
        cmd_p2 = '0;
        finish_test(e);

        cur_test = "lose_and_return";
        e = err_count;
        monitor_on = 1'b0;  // positions jump back to start under reset
        rst = 1'b1;
        repeat (4) @(negedge clk_25MHz);
        rst = 1'b0;
        monitor_on = 1'b1;
        press_start(lat);
        cmd_p2 = '{left: 1'b0, right: 1'b1, jump: 1'b0};
        t0 = cyc;
        while (pos_p2.x < 10'd69 && cyc - t0 < T_LOSE) @(negedge clk_25MHz);
        cmd_p2 = '0;  // park over the spike at column 3
        t0 = cyc;
        while (!(spike_on && spike_under(pos_p2)) && cyc - t0 < T_LOSE) @(negedge clk_25MHz);
        if (!(spike_on && spike_under(pos_p2))) fail_words("spikes never armed under player 2");
        t0 = cyc;
        while (scene != scene_lose && cyc - t0 < 20) @(negedge clk_25MHz);
        check("cycles to lose", 2, cyc - t0);
        ticks = 0;
        t0 = cyc;
        while (scene == scene_lose && cyc - t0 < T_LOSE) begin
            @(negedge clk_25MHz);
            if (m_tick_edge) ticks++;
        end
        check("scene after lose", scene_start, scene);
        check("ticks in lose", LOSE_TICKS, ticks);
        @(negedge clk_25MHz);
        t0 = cyc;
        while (!m_tick_edge && cyc - t0 < 2 * TICK_DIV) @(negedge clk_25MHz);
        check("pos_p1 reloaded in start", P1_START, pos_p1);
        check("pos_p2 reloaded in start", P2_START, pos_p2);
        finish_test(e);

        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
game_pkg.sv
game_timer.sv
button_debounce.sv
player_physics.sv
level_state.sv
scene_fsm.sv
game_top.sv
tb_game_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_game_top -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^ALL TESTS PASSED$"; then
    exit 0
fi
exit 1
